//--- bench/tb_eth_tx_model.svh
// Reference model for the Ethernet transmit testbench
// LFSR payload source, bitwise CRC-32 and the expected GMII stream
// of each table frame, kept in the queues of the testbench.

`ifndef TB_ETH_TX_MODEL_SVH
`define TB_ETH_TX_MODEL_SVH

// Galois LFSR stepped once for each bit taken, lsb first into the byte
function automatic logic [7:0] lfsr_byte();
    logic [7:0] b;
    int i;
    for (i = 0; i < 8; i++) begin
        b[i] = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return b;
endfunction

// reflected CRC-32 with the byte folded into the low bits first
function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    int i;
    c = crc ^ {24'h0, b};
    for (i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ eth_crc_poly;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

// queue the expected {tx_er, txd} bytes for payload[0 .. len-1]
task automatic add_expected(input int len, input bit err_last, input int underrun_pos);
    logic [31:0] crc;
    int n;
    int i;
    crc = eth_crc_init;
    n = (underrun_pos > 0) ? underrun_pos : len;
    for (i = 0; i < 8; i++) begin
        exp_stream.push_back({1'b0, (i == 7) ? eth_sfd_byte : eth_preamble_byte});
    end
    for (i = 0; i < n; i++) begin
        exp_stream.push_back({err_last && (i == len - 1), payload[i]});
        crc = crc_add_byte(crc, payload[i]);
    end
    if (underrun_pos > 0 || err_last) begin
        exp_err++;
    end else begin
        // zero pad up to the minimum frame without its FCS
        while (n < min_frame_len - 4) begin
            exp_stream.push_back(9'h000);
            crc = crc_add_byte(crc, 8'h00);
            n++;
        end
        for (i = 0; i < 4; i++) begin
            exp_stream.push_back({1'b0, ~crc[8*i +: 8]});
        end
        n += 4;
        exp_ok++;
    end
    exp_len.push_back(n + 8);
    exp_fall_er.push_back(underrun_pos > 0);
endtask

`endif

//--- bench/tb_eth_tx_top.sv
// Testbench for the Ethernet transmit top level
// Sends a table of frames through the DUT, captures each GMII burst
// and compares it with the reference model, then checks the counters.

`timescale 1ns/10ps
`default_nettype none

module tb_eth_tx_top
    import eth_tx_pkg::*;
();

    localparam int min_frame_len  = 64;
    localparam int fifo_depth     = 16;
    localparam int num_frames     = 8;
    localparam int timeout_cycles = 2000;

    typedef struct packed {
        logic [15:0] len;
        logic        err_last;
        logic [15:0] underrun_pos;
    } frame_entry_t;

    logic         clk;
    logic         reset_crc;
    axis_beat_t   in_beat;
    logic         in_valid;
    logic         in_ready;
    logic [7:0]   ifg_delay;
    gmii_tx_t     gmii_out;
    tx_stats_t    stats;

    frame_entry_t frame_table [num_frames];
    logic [7:0]   payload [256];
    logic [31:0]  lfsr_state;
    logic [8:0]   exp_stream [$];
    int           exp_len [$];
    logic         exp_fall_er [$];
    logic [8:0]   cur_burst [$];
    logic         prev_en = 1'b0;
    int           exp_ok;
    int           exp_err;
    int           cap_bytes;
    int           stall_cycles;
    int           gap_cycles;

    `include "tb_eth_tx_model.svh"

    eth_tx_top #(
        .ENABLE_PADDING   (1),
        .MIN_FRAME_LENGTH (min_frame_len),
        .FIFO_DEPTH       (fifo_depth)
    ) i_dut (
        .clk       (clk),
        .reset_crc (reset_crc),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .ifg_delay (ifg_delay),
        .gmii_out  (gmii_out),
        .stats     (stats)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // hold the beat until the FIFO takes it
    task automatic push_beat(input logic [7:0] data, input logic last, input logic user);
        int waited;
        waited = 0;
        in_beat  = {data, last, user};
        in_valid = 1'b1;
        while (!in_ready) begin
            stall_cycles++;
            wait_cycles(1);
            waited++;
            assert (waited < timeout_cycles) else stop_run("in_ready stayed low too long");
        end
        wait_cycles(1);
    endtask

    task automatic send_frame(input frame_entry_t f);
        int i;
        int waited;
        for (i = 0; i < f.len; i++) begin
            payload[i] = lfsr_byte();
        end
        add_expected(f.len, f.err_last, f.underrun_pos);
        for (i = 0; i < f.len; i++) begin
            if (f.underrun_pos != 0 && i == f.underrun_pos) begin
                // let the FIFO run dry until the framer marks the underrun
                in_valid = 1'b0;
                waited = 0;
                while (!(gmii_out.tx_er && !gmii_out.tx_en)) begin
                    wait_cycles(1);
                    waited++;
                    assert (waited < timeout_cycles) else begin
                        stop_run("no underrun mark while the FIFO ran dry");
                    end
                end
            end
            push_beat(payload[i], i == f.len - 1, f.err_last && i == f.len - 1);
        end
        in_valid = 1'b0;
    endtask

    task automatic check_burst(input logic fall_er);
        int i;
        assert (exp_len.size() > 0) else stop_run("a GMII burst appeared with no frame pending");
        check_hex("gmii_out.tx_en burst length", cur_burst.size(), exp_len.pop_front());
        for (i = 0; i < cur_burst.size(); i++) begin
            check_hex("gmii_out {tx_er, txd}", cur_burst[i], exp_stream.pop_front());
        end
        check_hex("gmii_out.tx_er after burst", fall_er, exp_fall_er.pop_front());
        cap_bytes += cur_burst.size();
        cur_burst.delete();
    endtask

    // gmii_out is registered and settled at the falling edge
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (gmii_out.tx_en) begin
                if (!prev_en) begin
                    // idle cycles since the previous burst
                    assert (gap_cycles >= ifg_delay) else begin
                        stop_run($sformatf("[FAIL] gmii_out.tx_en gap: got %h, expected >= %h",
                                           gap_cycles, ifg_delay));
                    end
                end
                cur_burst.push_back({gmii_out.tx_er, gmii_out.txd});
            end else if (prev_en) begin
                check_burst(gmii_out.tx_er);
                gap_cycles = 1;
            end else begin
                check_hex("gmii_out.tx_er between frames", gmii_out.tx_er, 0);
                gap_cycles++;
            end
            prev_en = gmii_out.tx_en;
        end
    end

    initial begin
        int i;
        int waited;
        clk          = 1'b0;
        reset_crc    = 1'b1;
        in_beat      = '0;
        in_valid     = 1'b0;
        ifg_delay    = 8'd12;
        lfsr_state   = 32'hc731_8bfd;
        exp_ok       = 0;
        exp_err      = 0;
        cap_bytes    = 0;
        stall_cycles = 0;
        gap_cycles   = timeout_cycles;
        // length, error on last, underrun position
        frame_table[0] = {16'd60, 1'b0, 16'd0};
        frame_table[1] = {16'd20, 1'b0, 16'd0};
        frame_table[2] = {16'd100, 1'b0, 16'd0};
        frame_table[3] = {16'd30, 1'b1, 16'd0};
        frame_table[4] = {16'd45, 1'b0, 16'd0};
        frame_table[5] = {16'd80, 1'b0, 16'd25};
        frame_table[6] = {16'd1, 1'b0, 16'd0};
        frame_table[7] = {16'd61, 1'b0, 16'd0};
        wait_cycles(5);
        reset_crc = 1'b0;
        check_hex("in_ready", in_ready, 1);
        check_hex("gmii_out.tx_en", gmii_out.tx_en, 0);
        check_hex("gmii_out.tx_er", gmii_out.tx_er, 0);
        check_hex("stats.frames_ok", stats.frames_ok, 0);
        check_hex("stats.frames_err", stats.frames_err, 0);
        check_hex("stats.bytes", stats.bytes, 0);
        for (i = 0; i < num_frames; i++) begin
            send_frame(frame_table[i]);
        end
        waited = 0;
        while (exp_len.size() > 0) begin
            wait_cycles(1);
            waited++;
            assert (waited < timeout_cycles) else stop_run("timed out waiting for GMII frames");
        end
        // let the last gap run out before reading the counters
        wait_cycles(16);
        check_hex("stats.frames_ok", stats.frames_ok, exp_ok);
        check_hex("stats.frames_err", stats.frames_err, exp_err);
        check_hex("stats.bytes", stats.bytes, cap_bytes);
        assert (stall_cycles > 0) else stop_run("in_ready never dropped while frames queued up");
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+bench
rtl/eth_tx_pkg.sv
rtl/tx_byte_fifo.sv
rtl/eth_crc32_byte.sv
rtl/eth_mac_1g_tx.sv
rtl/tx_frame_stats.sv
rtl/eth_tx_top.sv
bench/tb_eth_tx_top.sv

//--- rtl/eth_crc32_byte.sv
// Ethernet CRC-32 byte step
// Advances the reflected CRC-32 by one data byte, least significant
// bit first. Purely combinational, the bit loop unrolls into an XOR
// network.

`timescale 1ns/10ps
`default_nettype none

module eth_crc32_byte
    import eth_tx_pkg::*;
(
    input  wire [7:0]  data,
    input  wire [31:0] crc_in,
    output logic [31:0] crc_out
);

    logic [31:0] crc;

    always_comb begin
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            // shift right, fold in the polynomial when the outgoing bit differs
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ eth_crc_poly;
            end else begin
                crc = crc >> 1;
            end
        end
    end

    assign crc_out = crc;

endmodule

`default_nettype wire

//--- rtl/eth_mac_1g_tx.sv
// 1G Ethernet MAC transmit framer
// Takes payload bytes from the stream, sends preamble and SFD, pads
// short frames, appends the FCS and holds the inter-frame gap on a
// GMII byte interface. Underrun and error-on-last are flagged with
// tx_er. All outputs are registered.

`timescale 1ns/10ps
`default_nettype none

module eth_mac_1g_tx
    import eth_tx_pkg::*;
#(
    parameter int ENABLE_PADDING   = 1,
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  wire        clk,
    input  wire        reset_crc,

    // payload stream
    input  axis_beat_t beat,
    input  wire        beat_valid,
    output logic       beat_ready,

    // GMII output
    output gmii_tx_t   gmii,

    // minimum gap between frames, in cycles
    input  wire [7:0]  ifg_delay
);

    localparam logic [2:0] state_idle     = 3'd0;
    localparam logic [2:0] state_preamble = 3'd1;
    localparam logic [2:0] state_payload  = 3'd2;
    localparam logic [2:0] state_pad      = 3'd3;
    localparam logic [2:0] state_fcs      = 3'd4;
    localparam logic [2:0] state_wait_end = 3'd5;
    localparam logic [2:0] state_ifg      = 3'd6;

    // index of the last byte before the FCS on a minimum size frame
    localparam logic [15:0] pad_last = 16'(MIN_FRAME_LENGTH - 5);

    logic [2:0]  state_reg;
    logic [2:0]  state_next;
    logic [15:0] frame_ptr_reg;
    logic [15:0] frame_ptr_next;

    logic        beat_ready_reg;
    logic        beat_ready_next;
    gmii_tx_t    gmii_reg;
    gmii_tx_t    gmii_next;

    logic        crc_clear;
    logic        crc_update;
    logic [31:0] crc_state;
    logic [31:0] crc_next;

    logic        ifg_done;

    assign beat_ready = beat_ready_reg;
    assign gmii       = gmii_reg;

    // gap has run out once the count reaches ifg_delay
    assign ifg_done = (frame_ptr_reg + 16'd1) >= {8'h00, ifg_delay};

    // crc follows the byte about to be driven
    eth_crc32_byte i_crc (
        .data    (gmii_next.txd),
        .crc_in  (crc_state),
        .crc_out (crc_next)
    );

    always_comb begin
        state_next      = state_reg;
        frame_ptr_next  = frame_ptr_reg;
        beat_ready_next = 1'b0;
        gmii_next       = '0;
        crc_clear       = 1'b0;
        crc_update      = 1'b0;

        case (state_reg)
            state_idle: begin
                crc_clear = 1'b1;
                if (beat_valid) begin
                    frame_ptr_next  = 16'd1;
                    gmii_next.txd   = eth_preamble_byte;
                    gmii_next.tx_en = 1'b1;
                    state_next      = state_preamble;
                end
            end
            state_preamble: begin
                crc_clear       = 1'b1;
                frame_ptr_next  = frame_ptr_reg + 16'd1;
                gmii_next.txd   = eth_preamble_byte;
                gmii_next.tx_en = 1'b1;
                if (frame_ptr_reg == 16'd7) begin
                    // SFD goes out while the first payload byte is requested
                    frame_ptr_next  = 16'd0;
                    beat_ready_next = 1'b1;
                    gmii_next.txd   = eth_sfd_byte;
                    state_next      = state_payload;
                end
            end
            state_payload: begin
                crc_update      = 1'b1;
                beat_ready_next = 1'b1;
                frame_ptr_next  = frame_ptr_reg + 16'd1;
                gmii_next.txd   = beat.data;
                gmii_next.tx_en = 1'b1;
                if (beat_valid) begin
                    if (beat.last) begin
                        beat_ready_next = 1'b0;
                        if (beat.user) begin
                            // bad frame, no pad and no FCS
                            gmii_next.tx_er = 1'b1;
                            frame_ptr_next  = 16'd0;
                            state_next      = state_ifg;
                        end else if (ENABLE_PADDING != 0 && frame_ptr_reg < pad_last) begin
                            state_next = state_pad;
                        end else begin
                            frame_ptr_next = 16'd0;
                            state_next     = state_fcs;
                        end
                    end
                end else begin
                    // underrun, abort the frame and flush the rest
                    crc_update      = 1'b0;
                    gmii_next.txd   = 8'h00;
                    gmii_next.tx_en = 1'b0;
                    gmii_next.tx_er = 1'b1;
                    frame_ptr_next  = 16'd0;
                    state_next      = state_wait_end;
                end
            end
            state_pad: begin
                crc_update      = 1'b1;
                frame_ptr_next  = frame_ptr_reg + 16'd1;
                gmii_next.txd   = 8'h00;
                gmii_next.tx_en = 1'b1;
                if (frame_ptr_reg >= pad_last) begin
                    frame_ptr_next = 16'd0;
                    state_next     = state_fcs;
                end
            end
            state_fcs: begin
                frame_ptr_next  = frame_ptr_reg + 16'd1;
                gmii_next.tx_en = 1'b1;
                // low byte first
                case (frame_ptr_reg[1:0])
                    2'd0:    gmii_next.txd = ~crc_state[7:0];
                    2'd1:    gmii_next.txd = ~crc_state[15:8];
                    2'd2:    gmii_next.txd = ~crc_state[23:16];
                    default: gmii_next.txd = ~crc_state[31:24];
                endcase
                if (frame_ptr_reg[1:0] == 2'd3) begin
                    frame_ptr_next = 16'd0;
                    state_next     = state_ifg;
                end
            end
            state_wait_end: begin
                // drop beats up to last, the gap count keeps running
                crc_clear       = 1'b1;
                beat_ready_next = 1'b1;
                frame_ptr_next  = frame_ptr_reg + 16'd1;
                if (beat_valid && beat.last) begin
                    beat_ready_next = 1'b0;
                    state_next      = ifg_done ? state_idle : state_ifg;
                end
            end
            state_ifg: begin
                crc_clear      = 1'b1;
                frame_ptr_next = frame_ptr_reg + 16'd1;
                if (ifg_done) begin
                    state_next = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg      <= state_idle;
            frame_ptr_reg  <= 16'd0;
            beat_ready_reg <= 1'b0;
            gmii_reg       <= '0;
            crc_state      <= eth_crc_init;
        end else begin
            state_reg      <= state_next;
            frame_ptr_reg  <= frame_ptr_next;
            beat_ready_reg <= beat_ready_next;
            gmii_reg       <= gmii_next;
            if (crc_clear) begin
                crc_state <= eth_crc_init;
            end else if (crc_update) begin
                crc_state <= crc_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/eth_tx_pkg.sv
// Ethernet transmit package
// Frame constants shared by the framer and the CRC step, and the
// packed structs for the byte stream, the GMII lines and the
// statistics counter set.

`default_nettype none

package eth_tx_pkg;

    // preamble and start-of-frame delimiter bytes
    localparam logic [7:0] eth_preamble_byte = 8'h55;
    localparam logic [7:0] eth_sfd_byte      = 8'hd5;

    // reflected CRC-32, starting from all ones
    localparam logic [31:0] eth_crc_init = 32'hffff_ffff;
    localparam logic [31:0] eth_crc_poly = 32'hedb8_8320;

    // one stream beat, one byte wide
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // on the last beat this marks a bad frame
        logic       user;
    } axis_beat_t;

    // GMII transmit lines
    typedef struct packed {
        logic [7:0] txd;
        logic       tx_en;
        logic       tx_er;
    } gmii_tx_t;

    // counters, all wrap at 32 bits
    typedef struct packed {
        logic [31:0] frames_ok;
        logic [31:0] frames_err;
        // every cycle with tx_en high, preamble included
        logic [31:0] bytes;
    } tx_stats_t;

endpackage

`default_nettype wire

//--- rtl/eth_tx_top.sv
// Ethernet transmit top level
// Input FIFO, framer and statistics block on one clock. Frame
// parameters are set here and passed down.

`timescale 1ns/10ps
`default_nettype none

module eth_tx_top
    import eth_tx_pkg::*;
#(
    parameter int ENABLE_PADDING   = 1,
    parameter int MIN_FRAME_LENGTH = 64,
    parameter int FIFO_DEPTH       = 16
) (
    input  wire        clk,
    input  wire        reset_crc,

    input  axis_beat_t in_beat,
    input  wire        in_valid,
    output logic       in_ready,

    input  wire [7:0]  ifg_delay,

    output gmii_tx_t   gmii_out,
    output tx_stats_t  stats
);

    axis_beat_t fifo_beat;
    logic       fifo_valid;
    logic       fifo_ready;
    gmii_tx_t   gmii;

    assign gmii_out = gmii;

    tx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .reset_crc (reset_crc),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    eth_mac_1g_tx #(
        .ENABLE_PADDING   (ENABLE_PADDING),
        .MIN_FRAME_LENGTH (MIN_FRAME_LENGTH)
    ) i_mac_tx (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .beat       (fifo_beat),
        .beat_valid (fifo_valid),
        .beat_ready (fifo_ready),
        .gmii       (gmii),
        .ifg_delay  (ifg_delay)
    );

    tx_frame_stats i_stats (
        .clk       (clk),
        .reset_crc (reset_crc),
        .gmii      (gmii),
        .stats     (stats)
    );

endmodule

`default_nettype wire

//--- rtl/tx_byte_fifo.sv
// Transmit byte FIFO
// First-word-fall-through buffer for stream beats ahead of the framer.
// Read and write pointers carry one extra bit so that full and empty
// can be told apart. A write and a read may happen in the same cycle.

`timescale 1ns/10ps
`default_nettype none

module tx_byte_fifo
    import eth_tx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire        clk,
    input  wire        reset_crc,

    // write side
    input  axis_beat_t in_beat,
    input  wire        in_valid,
    output logic       in_ready,

    // read side, head beat shown while not empty
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  wire        out_ready
);

    localparam int addr_w = $clog2(FIFO_DEPTH);

    axis_beat_t mem [FIFO_DEPTH];

    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   rd_ptr;
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign wr_addr = wr_ptr[addr_w-1:0];
    assign rd_addr = rd_ptr[addr_w-1:0];

    // same address, wrap bits differ
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) && (wr_addr == rd_addr);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_en = in_valid && !full;
    assign rd_en = out_ready && !empty;

    assign in_ready  = !full;
    assign out_valid = !empty;

    // head of the queue, read without a register stage
    assign out_beat = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/tx_frame_stats.sv
// Transmit frame statistics
// Watches the GMII lines and counts good frames, errored frames and
// cycles with tx_en high. A frame is errored if tx_er was seen at any
// point while tx_en was high or in the cycle where tx_en fell.

`timescale 1ns/10ps
`default_nettype none

module tx_frame_stats
    import eth_tx_pkg::*;
(
    input  wire       clk,
    input  wire       reset_crc,
    input  gmii_tx_t  gmii,
    output tx_stats_t stats
);

    tx_stats_t stats_reg;

    logic prev_en;
    logic err_flag;
    logic frame_end;
    logic frame_err;

    assign stats = stats_reg;

    assign frame_end = prev_en && !gmii.tx_en;
    // includes the cycle where tx_en falls, which carries the underrun mark
    assign frame_err = err_flag || gmii.tx_er;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            stats_reg <= '0;
            prev_en   <= 1'b0;
            err_flag  <= 1'b0;
        end else begin
            prev_en <= gmii.tx_en;

            // sticky for the current frame only
            if (gmii.tx_en) begin
                err_flag <= frame_err;
            end else begin
                err_flag <= 1'b0;
            end

            if (gmii.tx_en) begin
                stats_reg.bytes <= stats_reg.bytes + 32'd1;
            end

            if (frame_end) begin
                if (frame_err) begin
                    stats_reg.frames_err <= stats_reg.frames_err + 32'd1;
                end else begin
                    stats_reg.frames_ok <= stats_reg.frames_ok + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
